// File: list.f
verilog/fft_pkg.sv
verilog/stage_ctrl.sv
verilog/pair_counter.sv
verilog/twiddle_rom.sv
verilog/radix2_butterfly.sv
verilog/complex_multiplier.sv
verilog/fft_stage_top.sv
testbench/fft_stage_asserts.sv
testbench/tb_fft_stage.sv

// File: Bender.yml
package:
  name: fft_stage

sources:
  - verilog/fft_pkg.sv
  - verilog/stage_ctrl.sv
  - verilog/pair_counter.sv
  - verilog/twiddle_rom.sv
  - verilog/radix2_butterfly.sv
  - verilog/complex_multiplier.sv
  - verilog/fft_stage_top.sv
  - target: simulation
    files:
      - testbench/fft_stage_asserts.sv
      - testbench/tb_fft_stage.sv

// File: testbench/tb_fft_stage.sv
`timescale 1ns/10ps

module tb_fft_stage import fft_pkg::*;;

    logic  clk;
    logic  rst_n;
    logic  start;
    logic  in_valid;
    cplx_t a;
    cplx_t b;
    logic  out_valid;
    cplx_t sum;
    cplx_t diff_rot;
    logic  busy;
    logic  done;

    int    seed = 32'h8759;
    int    err_value = 0;
    int    err_other = 0;
    int    err_assert = 0;
    int    cyc = 0;
    // Frame model kept apart from the DUT
    logic  model_open = 1'b0;
    int    model_k = 0;
    cplx_t exp_sum [$];
    cplx_t exp_rot [$];
    logic  exp_last [$];
    int    exp_due [$];

    fft_stage_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .sum       (sum),
        .diff_rot  (diff_rot),
        .busy      (busy),
        .done      (done)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    //************************************************************************
    // Reference model
    //************************************************************************
    function automatic longint nearest_int(input real x);
        if (x < 0.0) begin
            return -longint'($floor(0.5 - x));
        end else begin
            return longint'($floor(x + 0.5));
        end
    endfunction

    function automatic cplx_t ref_sum(input cplx_t av, input cplx_t bv);
        int    re;
        int    im;
        cplx_t r;
        re = (int'($signed(av.part.re)) + int'($signed(bv.part.re))) >>> 1;
        im = (int'($signed(av.part.im)) + int'($signed(bv.part.im))) >>> 1;
        r.part.re = sample_w'(re);
        r.part.im = sample_w'(im);
        return r;
    endfunction

    function automatic cplx_t ref_rot(input cplx_t av, input cplx_t bv, input int k);
        real    ang;
        longint wre;
        longint wim;
        longint dre;
        longint dim;
        cplx_t  r;
        ang = 6.283185307179586 * k / 256.0;
        wre = nearest_int($cos(ang) * 32768.0);
        wim = nearest_int(-$sin(ang) * 32768.0);
        dre = (longint'($signed(av.part.re)) - longint'($signed(bv.part.re))) >>> 1;
        dim = (longint'($signed(av.part.im)) - longint'($signed(bv.part.im))) >>> 1;
        // Keep the low 17 bits after rescaling, so large products wrap
        r.part.re = sample_w'((dre * wre - dim * wim) >>> 15);
        r.part.im = sample_w'((dre * wim + dim * wre) >>> 15);
        return r;
    endfunction

    function automatic cplx_t rand_cplx();
        cplx_t r;
        r.raw = cplx_w'({$random(seed), $random(seed)});
        return r;
    endfunction

    //************************************************************************
    // Compare tasks and per-cycle driver
    //************************************************************************
    task automatic check_cplx(input string name, input cplx_t exp, input cplx_t got);
        if (got !== exp) begin
            err_value++;
            $display("Error %s expected %h got %h", name, exp.raw, got.raw);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            err_value++;
            $display("Error %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic check_outputs();
        if (exp_due.size() != 0 && exp_due[0] == cyc && out_valid !== 1'b1) begin
            err_other++;
            $display("A result did not appear on time at cycle %0d", cyc);
            void'(exp_sum.pop_front());
            void'(exp_rot.pop_front());
            void'(exp_last.pop_front());
            void'(exp_due.pop_front());
        end
        if (out_valid === 1'b1) begin
            if (exp_sum.size() == 0) begin
                err_other++;
                $display("out_valid was high with no pair in flight at cycle %0d", cyc);
            end else begin
                if (exp_due[0] != cyc) begin
                    err_other++;
                    $display("A result arrived at the wrong cycle %0d", cyc);
                end
                check_cplx("sum", exp_sum.pop_front(), sum);
                check_cplx("diff_rot", exp_rot.pop_front(), diff_rot);
                check_bit("done", exp_last.pop_front(), done);
                void'(exp_due.pop_front());
            end
        end else begin
            check_bit("done", 1'b0, done);
        end
    endtask

    task automatic step(input logic st, input logic vld, input cplx_t av, input cplx_t bv);
        @(negedge clk);
        check_outputs();
        check_bit("busy", model_open, busy);
        start    = st;
        in_valid = vld;
        a        = av;
        b        = bv;
        if (model_open && vld) begin
            exp_sum.push_back(ref_sum(av, bv));
            exp_rot.push_back(ref_rot(av, bv, model_k));
            exp_last.push_back(model_k == pair_n - 1);
            exp_due.push_back(cyc + pipe_lat);
            if (model_k == pair_n - 1) begin
                model_open = 1'b0;
            end
            model_k = (model_k + 1) % pair_n;
        end else if (!model_open && st) begin
            model_open = 1'b1;
            model_k    = 0;
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_sum.size() != 0 && n < 4 * pipe_lat) begin
            step(1'b0, 1'b0, '0, '0);
            n++;
        end
        if (exp_sum.size() != 0) begin
            err_other++;
            $display("Timed out waiting for %0d pending results", exp_sum.size());
            exp_sum.delete();
            exp_rot.delete();
            exp_last.delete();
            exp_due.delete();
        end
    endtask

    // Mode 0 back to back, 1 random gaps, 2 full-scale patterns
    task automatic run_pairs(input int mode, input int limit);
        int    n;
        int    r;
        logic  vld;
        cplx_t av;
        cplx_t bv;
        n = 0;
        while (model_open && n < limit) begin
            r   = $random(seed);
            vld = (mode == 1) ? r[0] : 1'b1;
            av  = rand_cplx();
            bv  = rand_cplx();
            if (mode == 2) begin
                case (n % 4)
                    0: begin
                        av.raw = {17'h0ffff, 17'h10000};
                        bv.raw = {17'h10000, 17'h0ffff};
                    end
                    1: begin
                        av.raw = {17'h10000, 17'h10000};
                        bv.raw = {17'h10000, 17'h10000};
                    end
                    2: begin
                        av.raw = {17'h0ffff, 17'h0ffff};
                        bv.raw = {17'h0ffff, 17'h0ffff};
                    end
                    default: begin
                        av.raw = {17'h10000, 17'h0ffff};
                        bv.raw = {17'h0ffff, 17'h10000};
                    end
                endcase
            end
            step(1'b0, vld, av, bv);
            n++;
        end
        if (model_open) begin
            err_other++;
            $display("Frame did not close within %0d cycles", limit);
        end
    endtask

    //************************************************************************
    // Directed tests
    //************************************************************************
    task automatic check_reset_idle();
        step(1'b0, 1'b0, '0, '0);
        check_bit("out_valid", 1'b0, out_valid);
        check_bit("done", 1'b0, done);
        // Strobes with no open frame
        repeat (8) step(1'b0, 1'b1, rand_cplx(), rand_cplx());
        repeat (5) step(1'b0, 1'b0, '0, '0);
    endtask

    task automatic run_full_frame();
        step(1'b1, 1'b0, '0, '0);
        run_pairs(0, pair_n);
        wait_drain();
    endtask

    task automatic run_gapped_frame();
        step(1'b1, 1'b0, '0, '0);
        run_pairs(1, 8 * pair_n);
        wait_drain();
    endtask

    task automatic restart_mid_frame();
        step(1'b1, 1'b0, '0, '0);
        repeat (50) step(1'b0, 1'b1, rand_cplx(), rand_cplx());
        step(1'b1, 1'b1, rand_cplx(), rand_cplx());
        run_pairs(0, 2 * pair_n);
        // Next frame opens while the tail of this one drains
        step(1'b1, 1'b0, '0, '0);
        run_pairs(1, 8 * pair_n);
        wait_drain();
    endtask

    task automatic drive_extremes();
        step(1'b1, 1'b0, '0, '0);
        run_pairs(2, pair_n);
        wait_drain();
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        start    = 1'b0;
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_reset_idle();
        run_full_frame();
        run_gapped_frame();
        restart_mid_frame();
        drive_extremes();
        step(1'b0, 1'b0, '0, '0);

        err_assert = u_dut.u_asserts.fail_cnt;
        $display("Summary: %0d value errors, %0d other errors, %0d assertion failures",
                 err_value, err_other, err_assert);
        if (err_value + err_other + err_assert == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: testbench/fft_stage_asserts.sv
`timescale 1ns/10ps

module fft_stage_asserts import fft_pkg::*; (
    input logic clk,
    input logic rst_n,
    input logic accept,
    input logic last,
    input logic busy,
    input logic out_valid,
    input logic done
);

    int unsigned fail_cnt = 0;

    // One result per accepted pair, a fixed pipeline depth later
    a_latency: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid == $past(accept, pipe_lat)
    ) else begin
        fail_cnt++;
        $error("out_valid does not follow accept by the pipeline latency");
    end

    // done marks the result of the final pair and nothing else
    a_done_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
            done == (out_valid && $past(accept && last, pipe_lat))
    ) else begin
        fail_cnt++;
        $error("done does not mark the result of the last pair");
    end

    // Frame already closed the cycle after its final pair was accepted
    a_frame_close: assert property (
        @(posedge clk) disable iff (!rst_n) done |-> !$past(busy, pipe_lat - 1)
    ) else begin
        fail_cnt++;
        $error("busy still high after the last pair of a frame");
    end

endmodule

bind fft_stage_top fft_stage_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .accept    (accept),
    .last      (last),
    .busy      (busy),
    .out_valid (out_valid),
    .done      (done)
);

// File: verilog/fft_stage_top.sv
`timescale 1ns/10ps

module fft_stage_top import fft_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start,
    input  logic  in_valid,
    input  cplx_t a,
    input  cplx_t b,
    output logic  out_valid,
    output cplx_t sum,
    output cplx_t diff_rot,
    output logic  busy,
    output logic  done
);

    logic           accept;
    logic [k_w-1:0] k;
    logic           last;
    cplx_t          w;
    cplx_t          diff;
    logic           bf_valid;
    logic           bf_last;

    //**************************************************************************
    // Frame control and twiddle index
    //**************************************************************************
    stage_ctrl u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .in_valid (in_valid),
        .last     (last),
        .accept   (accept),
        .busy     (busy)
    );

    pair_counter u_count (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .accept (accept),
        .k      (k),
        .last   (last)
    );

    twiddle_rom u_rom (
        .clk   (clk),
        .rst_n (rst_n),
        .k     (k),
        .w     (w)
    );

    //**************************************************************************
    // Datapath, sum and rotated difference leave together
    //**************************************************************************
    radix2_butterfly u_bfly (
        .clk      (clk),
        .rst_n    (rst_n),
        .accept   (accept),
        .last     (last),
        .a        (a),
        .b        (b),
        .sum      (sum),
        .diff     (diff),
        .valid    (bf_valid),
        .last_tag (bf_last)
    );

    complex_multiplier u_cmul (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (bf_valid),
        .in_last   (bf_last),
        .diff      (diff),
        .w         (w),
        .diff_rot  (diff_rot),
        .out_valid (out_valid),
        .out_last  (done)
    );

endmodule

// File: verilog/complex_multiplier.sv
`timescale 1ns/10ps

module complex_multiplier import fft_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_valid,
    input  logic  in_last,
    input  cplx_t diff,
    input  cplx_t w,
    output cplx_t diff_rot,
    output logic  out_valid,
    output logic  out_last
);

    // Full 17x17 products
    logic signed [cplx_w-1:0] p_rr;
    logic signed [cplx_w-1:0] p_ii;
    logic signed [cplx_w-1:0] p_ri;
    logic signed [cplx_w-1:0] p_ir;
    logic signed [cplx_w:0]   rot_re;
    logic signed [cplx_w:0]   rot_im;
    logic                     valid_q;
    logic                     last_q;

    //**************************************************************************
    // Stage one, the four partial products
    //**************************************************************************
    always_ff @(posedge clk) begin
        p_rr <= diff.part.re * w.part.re;
        p_ii <= diff.part.im * w.part.im;
        p_ri <= diff.part.re * w.part.im;
        p_ir <= diff.part.im * w.part.re;
    end

    assign rot_re = p_rr - p_ii;
    assign rot_im = p_ri + p_ir;

    //**************************************************************************
    // Stage two, combine and rescale
    //**************************************************************************
    always_ff @(posedge clk) begin
        // Shift out the twiddle fraction, upper bits wrap away
        diff_rot.part.re <= rot_re[tw_frac +: sample_w];
        diff_rot.part.im <= rot_im[tw_frac +: sample_w];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q   <= 1'b0;
            last_q    <= 1'b0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            valid_q   <= in_valid;
            last_q    <= in_last;
            out_valid <= valid_q;
            // Last flag only ever rises together with a result
            out_last  <= last_q & valid_q;
        end
    end

endmodule

// File: verilog/radix2_butterfly.sv
`timescale 1ns/10ps

module radix2_butterfly import fft_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  accept,
    input  logic  last,
    input  cplx_t a,
    input  cplx_t b,
    output cplx_t sum,
    output cplx_t diff,
    output logic  valid,
    output logic  last_tag
);

    // One guard bit, so the halved result always fits in 17 bits
    logic signed [sample_w:0] sum_re;
    logic signed [sample_w:0] sum_im;
    logic signed [sample_w:0] dif_re;
    logic signed [sample_w:0] dif_im;
    cplx_t                    sum_q;
    cplx_t                    sum_dly [pipe_lat-1];

    assign sum_re = a.part.re + b.part.re;
    assign sum_im = a.part.im + b.part.im;
    assign dif_re = a.part.re - b.part.re;
    assign dif_im = a.part.im - b.part.im;

    //**************************************************************************
    // Halved sum and difference
    //**************************************************************************
    always_ff @(posedge clk) begin
        // Dropping bit 0 is the arithmetic shift right by one
        sum_q.part.re <= sum_re[sample_w:1];
        sum_q.part.im <= sum_im[sample_w:1];
        diff.part.re  <= dif_re[sample_w:1];
        diff.part.im  <= dif_im[sample_w:1];
    end

    // Sum waits out the two multiplier stages
    always_ff @(posedge clk) begin
        sum_dly[0] <= sum_q;
        for (int i = 1; i < pipe_lat - 1; i++) begin
            sum_dly[i] <= sum_dly[i-1];
        end
    end

    assign sum = sum_dly[pipe_lat-2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid    <= 1'b0;
            last_tag <= 1'b0;
        end else begin
            valid    <= accept;
            last_tag <= accept & last;
        end
    end

endmodule

// File: verilog/twiddle_rom.sv
`timescale 1ns/10ps

module twiddle_rom import fft_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    input  logic [k_w-1:0] k,
    output cplx_t          w
);

    cplx_t rom [pair_n];

    // W256^0 .. W256^127, constant at elaboration
    for (genvar i = 0; i < pair_n; i++) begin : g_rom
        assign rom[i] = twiddle_of(i);
    end

    // Read register lines up with the butterfly output register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            w <= '0;
        end else begin
            w <= rom[k];
        end
    end

endmodule

// File: verilog/pair_counter.sv
`timescale 1ns/10ps

module pair_counter import fft_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start,
    input  logic           accept,
    output logic [k_w-1:0] k,
    output logic           last
);

    // Local copy of the frame state, so a start in mid-frame leaves k alone
    logic open_q;

    assign last = (k == k_w'(pair_n - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            k      <= '0;
            open_q <= 1'b0;
        end else if (start && !open_q) begin
            k      <= '0;
            open_q <= 1'b1;
        end else if (accept) begin
            // Wraps from 127 back to 0 at the end of a frame
            k <= k + 1'b1;
            if (last) begin
                open_q <= 1'b0;
            end
        end
    end

endmodule

// File: verilog/stage_ctrl.sv
`timescale 1ns/10ps

module stage_ctrl import fft_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic in_valid,
    input  logic last,
    output logic accept,
    output logic busy
);

    logic state;
    logic state_nxt;

    assign busy   = (state == st_run);
    // Strobes outside an open frame are dropped
    assign accept = in_valid & busy;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (start) begin
                    state_nxt = st_run;
                end
            end
            st_run: begin
                // Frame closes on the accept of the final pair
                if (accept && last) begin
                    state_nxt = st_idle;
                end
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

// File: verilog/fft_pkg.sv
package fft_pkg;

    //**************************************************************************
    // Transform geometry and number formats
    //**************************************************************************
    localparam int fft_n    = 256;
    localparam int pair_n   = fft_n / 2;
    localparam int k_w      = $clog2(pair_n);
    localparam int sample_w = 17;
    localparam int cplx_w   = 2 * sample_w;
    // Twiddle scale, 1.0 maps to 32768
    localparam int tw_frac  = 15;
    // Accepted pair to result, in cycles
    localparam int pipe_lat = 3;

    // Frame states
    localparam logic st_idle = 1'b0;
    localparam logic st_run  = 1'b1;

    localparam real two_pi = 6.283185307179586;

    // Complex sample, re in the upper half
    typedef union packed {
        logic [cplx_w-1:0] raw;
        struct packed {
            logic signed [sample_w-1:0] re;
            logic signed [sample_w-1:0] im;
        } part;
    } cplx_t;

    // Nearest integer, ties away from zero
    function automatic int round_away(input real x);
        if (x < 0.0) begin
            return -$rtoi(0.5 - x);
        end
        return $rtoi(x + 0.5);
    endfunction

    // W256^k = cos(2*pi*k/256) - j*sin(2*pi*k/256), scaled by 2^15
    function automatic cplx_t twiddle_of(input int k);
        real   ang;
        real   scale;
        cplx_t w;
        ang       = two_pi * k / fft_n;
        scale     = real'(1 << tw_frac);
        w.part.re = sample_w'(round_away($cos(ang) * scale));
        w.part.im = sample_w'(round_away(-$sin(ang) * scale));
        return w;
    endfunction

endpackage
